// File: verilog/ex_pkg.sv
// execute stage widths and alu, operand select, memory and csr operation codes
package ex_pkg;

  // data and address widths
  localparam int XLEN        = 64;
  localparam int GPR_ADDR_W  = 5;
  localparam int CSR_ADDR_W  = 12;
  localparam int SRAM_ADDR_W = 32;
  localparam int WMASK_W     = 8;

  // alu operations
  localparam int ALU_OP_W = 5;

  localparam logic [ALU_OP_W-1:0] ALU_ADD   = 5'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB   = 5'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL   = 5'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT   = 5'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 5'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR   = 5'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL   = 5'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA   = 5'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR    = 5'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND   = 5'd9;
  localparam logic [ALU_OP_W-1:0] ALU_PASSB = 5'd10; // lui

  // operand one select
  localparam logic SRC1_RS1 = 1'b0;
  localparam logic SRC1_PC  = 1'b1;

  // operand two select
  localparam int SRC2_SEL_W = 2;

  localparam logic [SRC2_SEL_W-1:0] SRC2_RS2  = 2'd0;
  localparam logic [SRC2_SEL_W-1:0] SRC2_IMM  = 2'd1;
  localparam logic [SRC2_SEL_W-1:0] SRC2_FOUR = 2'd2; // link address

  // memory access size, store sizes first
  localparam int MEM_OP_W = 3;

  localparam logic [MEM_OP_W-1:0] MEM_B  = 3'd0;
  localparam logic [MEM_OP_W-1:0] MEM_H  = 3'd1;
  localparam logic [MEM_OP_W-1:0] MEM_W  = 3'd2;
  localparam logic [MEM_OP_W-1:0] MEM_D  = 3'd3;
  localparam logic [MEM_OP_W-1:0] MEM_BU = 3'd4; // unsigned loads, passed on
  localparam logic [MEM_OP_W-1:0] MEM_HU = 3'd5;
  localparam logic [MEM_OP_W-1:0] MEM_WU = 3'd6;

  // csr operations
  localparam int CSR_OP_W = 3;

  localparam logic [CSR_OP_W-1:0] CSR_NONE = 3'd0;
  localparam logic [CSR_OP_W-1:0] CSR_RW   = 3'd1;
  localparam logic [CSR_OP_W-1:0] CSR_RS   = 3'd2;
  localparam logic [CSR_OP_W-1:0] CSR_RC   = 3'd3;
  localparam logic [CSR_OP_W-1:0] CSR_RWI  = 3'd4;
  localparam logic [CSR_OP_W-1:0] CSR_RSI  = 3'd5;
  localparam logic [CSR_OP_W-1:0] CSR_RCI  = 3'd6;

endpackage

// File: verilog/ex_stage_ctrl.sv
// execute stage control: valid bit, allowin, field registers, sram strobes, bypass masks
`timescale 1ns/1ps

module ex_stage_ctrl import ex_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_ms_allowin,
  output logic                   o_es_allowin,
  // from decode
  input  logic                   i_ds_valid,
  input  logic [XLEN-1:0]        i_rs1_data,
  input  logic [XLEN-1:0]        i_rs2_data,
  input  logic [XLEN-1:0]        i_csr_rdata,
  input  logic [XLEN-1:0]        i_imm,
  input  logic [XLEN-1:0]        i_pc,
  input  logic                   i_src1_sel,
  input  logic [SRC2_SEL_W-1:0]  i_src2_sel,
  input  logic                   i_word_cut,
  input  logic [ALU_OP_W-1:0]    i_alu_op,
  input  logic [GPR_ADDR_W-1:0]  i_rd,
  input  logic [CSR_ADDR_W-1:0]  i_csr,
  input  logic                   i_gpr_wen,
  input  logic                   i_csr_wen,
  input  logic                   i_mem_ren,
  input  logic                   i_mem_wen,
  input  logic [MEM_OP_W-1:0]    i_mem_op,
  input  logic                   i_csr_inst_sel,
  input  logic [CSR_OP_W-1:0]    i_csr_op,
  // results from the datapath
  input  logic [XLEN-1:0]        i_alu_result,
  input  logic [XLEN-1:0]        i_csr_result,
  // to memory stage
  output logic                   o_ms_valid,
  output logic [GPR_ADDR_W-1:0]  o_ms_rd,
  output logic [CSR_ADDR_W-1:0]  o_ms_csr,
  output logic                   o_ms_gpr_wen,
  output logic                   o_ms_csr_wen,
  output logic                   o_ms_mem_ren,
  output logic [MEM_OP_W-1:0]    o_ms_mem_op,
  output logic                   o_ms_csr_inst_sel,
  output logic [XLEN-1:0]        o_ms_csr_rdata,
  // registered operands and controls for the datapath
  output logic [XLEN-1:0]        o_rs1_data,
  output logic [XLEN-1:0]        o_rs2_data,
  output logic [XLEN-1:0]        o_imm,
  output logic [XLEN-1:0]        o_pc,
  output logic                   o_src1_sel,
  output logic [SRC2_SEL_W-1:0]  o_src2_sel,
  output logic                   o_word_cut,
  output logic [ALU_OP_W-1:0]    o_alu_op,
  output logic [CSR_OP_W-1:0]    o_csr_op,
  // sram strobes
  output logic                   o_sram_ren,
  output logic                   o_sram_wen,
  // bypass to decode
  output logic [GPR_ADDR_W-1:0]  o_byp_rd,
  output logic [XLEN-1:0]        o_byp_rd_data,
  output logic [CSR_ADDR_W-1:0]  o_byp_csr,
  output logic [XLEN-1:0]        o_byp_csr_data
);

  logic r_valid;
  logic r_mem_wen;
  logic accept;
  logic leave;

  // ready_go is always high, results are combinational
  assign o_es_allowin = !r_valid || i_ms_allowin;
  assign o_ms_valid   = r_valid;
  assign accept       = i_ds_valid && o_es_allowin;
  assign leave        = r_valid && i_ms_allowin;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_valid      <= 1'b0;
      r_mem_wen    <= 1'b0;
      o_ms_gpr_wen <= 1'b0;
      o_ms_csr_wen <= 1'b0;
      o_ms_mem_ren <= 1'b0;
    end else begin
      if (o_es_allowin) begin
        r_valid <= i_ds_valid;
      end
      if (accept) begin
        r_mem_wen    <= i_mem_wen;
        o_ms_gpr_wen <= i_gpr_wen;
        o_ms_csr_wen <= i_csr_wen;
        o_ms_mem_ren <= i_mem_ren;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_rs1_data        <= i_rs1_data;
      o_rs2_data        <= i_rs2_data;
      o_ms_csr_rdata    <= i_csr_rdata;
      o_imm             <= i_imm;
      o_pc              <= i_pc;
      o_src1_sel        <= i_src1_sel;
      o_src2_sel        <= i_src2_sel;
      o_word_cut        <= i_word_cut;
      o_alu_op          <= i_alu_op;
      o_ms_rd           <= i_rd;
      o_ms_csr          <= i_csr;
      o_ms_mem_op       <= i_mem_op;
      o_ms_csr_inst_sel <= i_csr_inst_sel;
      o_csr_op          <= i_csr_op;
    end
  end

  // one request per memory instruction, issued as it leaves
  assign o_sram_ren = leave && o_ms_mem_ren;
  assign o_sram_wen = leave && r_mem_wen;

  assign o_byp_rd       = (r_valid && o_ms_gpr_wen) ? o_ms_rd : '0;
  assign o_byp_rd_data  = (r_valid && o_ms_gpr_wen) ? i_alu_result : '0;
  assign o_byp_csr      = (r_valid && o_ms_csr_wen) ? o_ms_csr : '0;
  assign o_byp_csr_data = (r_valid && o_ms_csr_wen) ? i_csr_result : '0;

  a_sram_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(o_sram_ren && o_sram_wen));

  // stalled item keeps every field until memory takes it
  a_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (r_valid && !i_ms_allowin) |=> r_valid && $stable({o_rs1_data, o_rs2_data,
      o_ms_csr_rdata, o_imm, o_pc, o_src1_sel, o_src2_sel, o_word_cut, o_alu_op,
      o_ms_rd, o_ms_csr, o_ms_mem_op, o_ms_csr_inst_sel, o_csr_op, r_mem_wen,
      o_ms_gpr_wen, o_ms_csr_wen, o_ms_mem_ren}));

endmodule

// File: verilog/ex_alu.sv
// operand select and integer alu with w-form word cut
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
  input  logic [XLEN-1:0]        i_rs1_data,
  input  logic [XLEN-1:0]        i_rs2_data,
  input  logic [XLEN-1:0]        i_imm,
  input  logic [XLEN-1:0]        i_pc,
  input  logic                   i_src1_sel,
  input  logic [SRC2_SEL_W-1:0]  i_src2_sel,
  input  logic [ALU_OP_W-1:0]    i_alu_op,
  input  logic                   i_word_cut,
  output logic [XLEN-1:0]        o_result
);

  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [5:0]      shamt;
  logic [XLEN-1:0] srl_src;  // low word zero-extended when cut
  logic [XLEN-1:0] sra_src;  // low word sign-extended when cut
  logic [XLEN-1:0] raw;

  assign op1 = (i_src1_sel == SRC1_PC) ? i_pc : i_rs1_data;

  always_comb begin
    case (i_src2_sel)
      SRC2_RS2:  op2 = i_rs2_data;
      SRC2_IMM:  op2 = i_imm;
      SRC2_FOUR: op2 = 64'd4;
      default:   op2 = '0;
    endcase
  end

  // w-forms shift by five bits only
  assign shamt = i_word_cut ? {1'b0, op2[4:0]} : op2[5:0];

  assign srl_src = i_word_cut ? {32'b0, op1[31:0]} : op1;
  assign sra_src = i_word_cut ? {{32{op1[31]}}, op1[31:0]} : op1;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:   raw = op1 + op2;
      ALU_SUB:   raw = op1 - op2;
      ALU_SLL:   raw = op1 << shamt;
      ALU_SLT:   raw = {63'b0, $signed(op1) < $signed(op2)};
      ALU_SLTU:  raw = {63'b0, op1 < op2};
      ALU_XOR:   raw = op1 ^ op2;
      ALU_SRL:   raw = srl_src >> shamt;
      ALU_SRA:   raw = $unsigned($signed(sra_src) >>> shamt);
      ALU_OR:    raw = op1 | op2;
      ALU_AND:   raw = op1 & op2;
      ALU_PASSB: raw = op2;
      default:   raw = '0;
    endcase
  end

  assign o_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

  // decode must never hand over an undefined op
  always_comb begin
    if (!$isunknown({i_alu_op, i_src1_sel, i_src2_sel, i_word_cut})) begin
      a_alu_op: assert final (i_alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
                                                ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
                                                ALU_OR, ALU_AND, ALU_PASSB})
        else $error("ex_alu: undefined alu op %0d", i_alu_op);
    end
  end

endmodule

// File: verilog/ex_csr_alu.sv
// csr write value for register and immediate forms
`timescale 1ns/1ps

module ex_csr_alu import ex_pkg::*; (
  input  logic [CSR_OP_W-1:0] i_csr_op,
  input  logic [XLEN-1:0]     i_csr_rdata,
  input  logic [XLEN-1:0]     i_rs1_data,
  input  logic [XLEN-1:0]     i_imm,
  output logic [XLEN-1:0]     o_csr_result
);

  logic            imm_form;
  logic [XLEN-1:0] src;

  assign imm_form = (i_csr_op == CSR_RWI) || (i_csr_op == CSR_RSI) ||
                    (i_csr_op == CSR_RCI);

  // uimm sits in the low five immediate bits
  assign src = imm_form ? {{(XLEN-5){1'b0}}, i_imm[4:0]} : i_rs1_data;

  always_comb begin
    case (i_csr_op)
      CSR_RW, CSR_RWI: o_csr_result = src;
      CSR_RS, CSR_RSI: o_csr_result = i_csr_rdata | src;
      CSR_RC, CSR_RCI: o_csr_result = i_csr_rdata & ~src;
      CSR_NONE:        o_csr_result = i_csr_rdata;
      default:         o_csr_result = i_csr_rdata;
    endcase
  end

endmodule

// File: verilog/ex_store_align.sv
// store byte mask and write data lane placement
`timescale 1ns/1ps

module ex_store_align import ex_pkg::*; (
  input  logic [MEM_OP_W-1:0] i_mem_op,
  input  logic [2:0]          i_addr_low,
  input  logic [XLEN-1:0]     i_rs2_data,
  input  logic                i_check_en,   // sram write strobe
  output logic [WMASK_W-1:0]  o_wmask,
  output logic [XLEN-1:0]     o_wdata
);

  logic [WMASK_W-1:0] base_mask;
  logic [XLEN-1:0]    base_data;
  logic [2:0]         align_bits;   // offset bits that must be zero

  always_comb begin
    case (i_mem_op)
      MEM_B: begin
        base_mask  = 8'h01;
        base_data  = {56'b0, i_rs2_data[7:0]};
        align_bits = 3'b000;
      end
      MEM_H: begin
        base_mask  = 8'h03;
        base_data  = {48'b0, i_rs2_data[15:0]};
        align_bits = 3'b001;
      end
      MEM_W: begin
        base_mask  = 8'h0f;
        base_data  = {32'b0, i_rs2_data[31:0]};
        align_bits = 3'b011;
      end
      MEM_D: begin
        base_mask  = 8'hff;
        base_data  = i_rs2_data;
        align_bits = 3'b111;
      end
      MEM_BU, MEM_HU, MEM_WU: begin  // loads only
        base_mask  = '0;
        base_data  = '0;
        align_bits = 3'b000;
      end
      default: begin
        base_mask  = '0;
        base_data  = '0;
        align_bits = 3'b000;
      end
    endcase
  end

  assign o_wmask = base_mask << i_addr_low;
  assign o_wdata = base_data << {i_addr_low, 3'b000};

  // no misalign trap here, the address must come in aligned
  always_comb begin
    if (i_check_en) begin
      a_store_align: assert final ((i_addr_low & align_bits) == 3'b000)
        else $error("ex_store_align: misaligned store, op %0d offset %0d",
                    i_mem_op, i_addr_low);
    end
  end

endmodule

// File: verilog/ex_top.sv
// execute stage top: controller, alu, csr alu and store aligner
`timescale 1ns/1ps

module ex_top import ex_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  // decode side
  input  logic                   i_ds_valid,
  output logic                   o_es_allowin,
  input  logic [XLEN-1:0]        i_rs1_data,
  input  logic [XLEN-1:0]        i_rs2_data,
  input  logic [XLEN-1:0]        i_csr_rdata,
  input  logic [XLEN-1:0]        i_imm,
  input  logic [XLEN-1:0]        i_pc,
  input  logic                   i_src1_sel,
  input  logic [SRC2_SEL_W-1:0]  i_src2_sel,
  input  logic                   i_word_cut,
  input  logic [ALU_OP_W-1:0]    i_alu_op,
  input  logic [GPR_ADDR_W-1:0]  i_rd,
  input  logic [CSR_ADDR_W-1:0]  i_csr,
  input  logic                   i_gpr_wen,
  input  logic                   i_csr_wen,
  input  logic                   i_mem_ren,
  input  logic                   i_mem_wen,
  input  logic [MEM_OP_W-1:0]    i_mem_op,
  input  logic                   i_csr_inst_sel,
  input  logic [CSR_OP_W-1:0]    i_csr_op,
  // memory stage side
  input  logic                   i_ms_allowin,
  output logic                   o_ms_valid,
  output logic [GPR_ADDR_W-1:0]  o_ms_rd,
  output logic [CSR_ADDR_W-1:0]  o_ms_csr,
  output logic                   o_ms_gpr_wen,
  output logic                   o_ms_csr_wen,
  output logic                   o_ms_mem_ren,
  output logic [MEM_OP_W-1:0]    o_ms_mem_op,
  output logic                   o_ms_csr_inst_sel,
  output logic [XLEN-1:0]        o_ms_csr_rdata,
  output logic [XLEN-1:0]        o_ms_alu_result,
  output logic [XLEN-1:0]        o_ms_csr_result,
  // data sram
  output logic [SRAM_ADDR_W-1:0] o_sram_addr,
  output logic                   o_sram_ren,
  output logic                   o_sram_wen,
  output logic [WMASK_W-1:0]     o_sram_wmask,
  output logic [XLEN-1:0]        o_sram_wdata,
  // bypass
  output logic [GPR_ADDR_W-1:0]  o_byp_rd,
  output logic [XLEN-1:0]        o_byp_rd_data,
  output logic [CSR_ADDR_W-1:0]  o_byp_csr,
  output logic [XLEN-1:0]        o_byp_csr_data
);

  logic [XLEN-1:0]       es_rs1_data;
  logic [XLEN-1:0]       es_rs2_data;
  logic [XLEN-1:0]       es_imm;
  logic [XLEN-1:0]       es_pc;
  logic                  es_src1_sel;
  logic [SRC2_SEL_W-1:0] es_src2_sel;
  logic                  es_word_cut;
  logic [ALU_OP_W-1:0]   es_alu_op;
  logic [CSR_OP_W-1:0]   es_csr_op;

  ex_stage_ctrl u_ctrl (
    .i_clk             (i_clk),
    .i_arst_n          (i_arst_n),
    .i_ms_allowin      (i_ms_allowin),
    .o_es_allowin      (o_es_allowin),
    .i_ds_valid        (i_ds_valid),
    .i_rs1_data        (i_rs1_data),
    .i_rs2_data        (i_rs2_data),
    .i_csr_rdata       (i_csr_rdata),
    .i_imm             (i_imm),
    .i_pc              (i_pc),
    .i_src1_sel        (i_src1_sel),
    .i_src2_sel        (i_src2_sel),
    .i_word_cut        (i_word_cut),
    .i_alu_op          (i_alu_op),
    .i_rd              (i_rd),
    .i_csr             (i_csr),
    .i_gpr_wen         (i_gpr_wen),
    .i_csr_wen         (i_csr_wen),
    .i_mem_ren         (i_mem_ren),
    .i_mem_wen         (i_mem_wen),
    .i_mem_op          (i_mem_op),
    .i_csr_inst_sel    (i_csr_inst_sel),
    .i_csr_op          (i_csr_op),
    .i_alu_result      (o_ms_alu_result),
    .i_csr_result      (o_ms_csr_result),
    .o_ms_valid        (o_ms_valid),
    .o_ms_rd           (o_ms_rd),
    .o_ms_csr          (o_ms_csr),
    .o_ms_gpr_wen      (o_ms_gpr_wen),
    .o_ms_csr_wen      (o_ms_csr_wen),
    .o_ms_mem_ren      (o_ms_mem_ren),
    .o_ms_mem_op       (o_ms_mem_op),
    .o_ms_csr_inst_sel (o_ms_csr_inst_sel),
    .o_ms_csr_rdata    (o_ms_csr_rdata),
    .o_rs1_data        (es_rs1_data),
    .o_rs2_data        (es_rs2_data),
    .o_imm             (es_imm),
    .o_pc              (es_pc),
    .o_src1_sel        (es_src1_sel),
    .o_src2_sel        (es_src2_sel),
    .o_word_cut        (es_word_cut),
    .o_alu_op          (es_alu_op),
    .o_csr_op          (es_csr_op),
    .o_sram_ren        (o_sram_ren),
    .o_sram_wen        (o_sram_wen),
    .o_byp_rd          (o_byp_rd),
    .o_byp_rd_data     (o_byp_rd_data),
    .o_byp_csr         (o_byp_csr),
    .o_byp_csr_data    (o_byp_csr_data)
  );

  ex_alu u_alu (
    .i_rs1_data (es_rs1_data),
    .i_rs2_data (es_rs2_data),
    .i_imm      (es_imm),
    .i_pc       (es_pc),
    .i_src1_sel (es_src1_sel),
    .i_src2_sel (es_src2_sel),
    .i_alu_op   (es_alu_op),
    .i_word_cut (es_word_cut),
    .o_result   (o_ms_alu_result)
  );

  ex_csr_alu u_csr_alu (
    .i_csr_op     (es_csr_op),
    .i_csr_rdata  (o_ms_csr_rdata),
    .i_rs1_data   (es_rs1_data),
    .i_imm        (es_imm),
    .o_csr_result (o_ms_csr_result)
  );

  // rs1 + imm gives the store address
  ex_store_align u_store_align (
    .i_mem_op   (o_ms_mem_op),
    .i_addr_low (o_ms_alu_result[2:0]),
    .i_rs2_data (es_rs2_data),
    .i_check_en (o_sram_wen),
    .o_wmask    (o_sram_wmask),
    .o_wdata    (o_sram_wdata)
  );

  assign o_sram_addr = o_ms_alu_result[SRAM_ADDR_W-1:0];

endmodule

// File: sim/tb_ex_top.sv
// execute stage testbench: alu and csr reference model, compare tasks, directed tests
`timescale 1ns/1ps

module tb_ex_top import ex_pkg::*; ();

  localparam int TIMEOUT = 20;  // cycles allowed per wait

  logic                   i_clk, i_arst_n, i_ds_valid, i_ms_allowin;
  logic [XLEN-1:0]        i_rs1_data, i_rs2_data, i_csr_rdata, i_imm, i_pc;
  logic                   i_src1_sel, i_word_cut, i_csr_inst_sel;
  logic [SRC2_SEL_W-1:0]  i_src2_sel;
  logic [ALU_OP_W-1:0]    i_alu_op;
  logic [GPR_ADDR_W-1:0]  i_rd;
  logic [CSR_ADDR_W-1:0]  i_csr;
  logic                   i_gpr_wen, i_csr_wen, i_mem_ren, i_mem_wen;
  logic [MEM_OP_W-1:0]    i_mem_op;
  logic [CSR_OP_W-1:0]    i_csr_op;
  logic                   o_es_allowin, o_ms_valid, o_ms_gpr_wen, o_ms_csr_wen;
  logic                   o_ms_mem_ren, o_ms_csr_inst_sel, o_sram_ren, o_sram_wen;
  logic [GPR_ADDR_W-1:0]  o_ms_rd, o_byp_rd;
  logic [CSR_ADDR_W-1:0]  o_ms_csr, o_byp_csr;
  logic [MEM_OP_W-1:0]    o_ms_mem_op;
  logic [XLEN-1:0]        o_ms_csr_rdata, o_ms_alu_result, o_ms_csr_result;
  logic [XLEN-1:0]        o_sram_wdata, o_byp_rd_data, o_byp_csr_data;
  logic [SRAM_ADDR_W-1:0] o_sram_addr;
  logic [WMASK_W-1:0]     o_sram_wmask;

  int seed    = 32'hc110;
  int err_cnt = 0;
  int chk_cnt = 0;

  ex_top i_ex_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // hard stop in case a test loses its way
  initial begin
    #100000;
    $display("watchdog: simulation ran past its time limit");
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic logic [XLEN-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // reference alu with w-form results cut to 32 bits and sign-extended
  function automatic logic [XLEN-1:0] model_alu(input logic [ALU_OP_W-1:0] op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b,
                                                input logic wc);
    logic [XLEN-1:0] r;
    logic [31:0]     lo;
    int              sh;
    lo = a[31:0];
    sh = wc ? int'(b[4:0]) : int'(b[5:0]);
    case (op)
      ALU_ADD:   r = a + b;
      ALU_SUB:   r = a - b;
      ALU_SLL:   r = a << sh;
      ALU_SLT:   r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      ALU_SLTU:  r = (a < b) ? 64'd1 : 64'd0;
      ALU_XOR:   r = a ^ b;
      ALU_SRL:   r = wc ? {32'b0, lo >> sh} : a >> sh;
      ALU_SRA:   r = wc ? {32'b0, $signed(lo) >>> sh} : $unsigned($signed(a) >>> sh);
      ALU_OR:    r = a | b;
      ALU_AND:   r = a & b;
      ALU_PASSB: r = b;
      default:   r = '0;
    endcase
    if (wc) r = {{32{r[31]}}, r[31:0]};
    return r;
  endfunction

  function automatic logic [XLEN-1:0] model_csr(input logic [CSR_OP_W-1:0] op,
                                                input logic [XLEN-1:0] old,
                                                input logic [XLEN-1:0] rs1,
                                                input logic [XLEN-1:0] imm);
    logic [XLEN-1:0] src;
    src = (op == CSR_RWI || op == CSR_RSI || op == CSR_RCI) ? XLEN'(imm[4:0]) : rs1;
    case (op)
      CSR_RW, CSR_RWI: return src;
      CSR_RS, CSR_RSI: return old | src;
      CSR_RC, CSR_RCI: return old & ~src;
      default:         return old;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_mask(input string name, input logic [WMASK_W-1:0] got,
                            input logic [WMASK_W-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_strobes(input string what, input int nr, input int nw,
                               input int exp_r, input int exp_w);
    chk_cnt++;
    if (nr != exp_r || nw != exp_w) begin
      err_cnt++;
      $display("%s gave %0d read and %0d write strobes, wanted %0d and %0d at %0t",
               what, nr, nw, exp_r, exp_w, $time);
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s at %0t", what, $time);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic report_test(input string name, input int e0);
    $display("test %s finished with %0d errors", name, err_cnt - e0);
  endtask

  task automatic clear_fields();
    i_ds_valid     = 1'b0;
    i_rs1_data     = '0;
    i_rs2_data     = '0;
    i_csr_rdata    = '0;
    i_imm          = '0;
    i_pc           = '0;
    i_src1_sel     = SRC1_RS1;
    i_src2_sel     = SRC2_RS2;
    i_word_cut     = 1'b0;
    i_alu_op       = ALU_ADD;
    i_rd           = '0;
    i_csr          = '0;
    i_gpr_wen      = 1'b0;
    i_csr_wen      = 1'b0;
    i_mem_ren      = 1'b0;
    i_mem_wen      = 1'b0;
    i_mem_op       = MEM_B;
    i_csr_inst_sel = 1'b0;
    i_csr_op       = CSR_NONE;
  endtask

  // starts 1 ns after an edge and returns 1 ns after the accepting edge
  task automatic issue();
    int n;
    n = 0;
    i_ds_valid = 1'b1;
    @(negedge i_clk);
    while (!o_es_allowin && n < TIMEOUT) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_es_allowin) begin
      abort_run("decode handshake stuck, o_es_allowin never rose");
    end else begin
      @(posedge i_clk);
      #1;
      i_ds_valid = 1'b0;
    end
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    while (!o_ms_valid && n < TIMEOUT) begin
      @(posedge i_clk);
      #1;
      n++;
    end
    if (!o_ms_valid) begin
      abort_run("o_ms_valid never rose after acceptance");
    end else begin
      chk_cnt++;
      if (n != 0) begin
        err_cnt++;
        $display("o_ms_valid rose %0d cycles after acceptance at %0t", n + 1, $time);
      end
    end
  endtask

  // first sample is the current cycle
  task automatic count_strobes(input int cycles, output int nr, output int nw);
    nr = 0;
    nw = 0;
    for (int c = 0; c < cycles; c++) begin
      if (c > 0) @(negedge i_clk);
      nr += int'(o_sram_ren);
      nw += int'(o_sram_wen);
    end
  endtask

  task automatic check_idle();
    check_bit("o_ms_valid", o_ms_valid, 1'b0);
    check_bit("o_sram_ren", o_sram_ren, 1'b0);
    check_bit("o_sram_wen", o_sram_wen, 1'b0);
    check_bit("o_es_allowin", o_es_allowin, 1'b1);
    check_word("o_byp_rd", XLEN'(o_byp_rd), '0);
    check_word("o_byp_rd_data", o_byp_rd_data, '0);
    check_word("o_byp_csr", XLEN'(o_byp_csr), '0);
    check_word("o_byp_csr_data", o_byp_csr_data, '0);
  endtask

  task automatic test_reset();
    int e0;
    e0 = err_cnt;
    i_arst_n = 1'b0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    check_idle();  // still in reset
    repeat (2) @(posedge i_clk);
    #1;
    i_arst_n = 1'b1;
    @(negedge i_clk);
    check_idle();
    report_test("reset", e0);
  endtask

  task automatic test_alu();
    int              e0;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] exp;
    e0 = err_cnt;
    for (int k = 0; k <= 10; k++) begin
      for (int s1 = 0; s1 < 2; s1++) begin
        for (int s2 = 0; s2 < 3; s2++) begin
          for (int wc = 0; wc < 2; wc++) begin
            @(posedge i_clk);
            #1;
            clear_fields();
            i_alu_op   = ALU_OP_W'(k);
            i_src1_sel = 1'(s1);
            i_src2_sel = SRC2_SEL_W'(s2);
            i_word_cut = 1'(wc);
            i_rs1_data = rand64();
            i_rs2_data = rand64();
            i_imm      = rand64();
            i_pc       = rand64();
            i_rd       = GPR_ADDR_W'(k + 1);
            i_gpr_wen  = 1'b1;
            op1 = (i_src1_sel == SRC1_PC) ? i_pc : i_rs1_data;
            case (i_src2_sel)
              SRC2_IMM:  op2 = i_imm;
              SRC2_FOUR: op2 = 64'd4;
              default:   op2 = i_rs2_data;
            endcase
            exp = model_alu(i_alu_op, op1, op2, i_word_cut);
            issue();
            wait_valid();
            @(negedge i_clk);
            check_word("o_ms_alu_result", o_ms_alu_result, exp);
          end
        end
      end
    end
    report_test("alu", e0);
  endtask

  task automatic test_csr();
    int              e0;
    logic [XLEN-1:0] exp;
    logic [XLEN-1:0] old;
    e0 = err_cnt;
    for (int k = 0; k < 7; k++) begin
      @(posedge i_clk);
      #1;
      clear_fields();
      i_csr_op       = CSR_OP_W'(k);
      i_csr_rdata    = rand64();
      i_rs1_data     = rand64();
      i_imm          = rand64();
      i_csr          = CSR_ADDR_W'(k + 'h300);
      i_csr_wen      = (i_csr_op != CSR_NONE);
      i_csr_inst_sel = 1'(k);
      old = i_csr_rdata;
      exp = model_csr(i_csr_op, i_csr_rdata, i_rs1_data, i_imm);
      issue();
      wait_valid();
      @(negedge i_clk);
      check_word("o_ms_csr_result", o_ms_csr_result, exp);
      check_word("o_ms_csr_rdata", o_ms_csr_rdata, old);
      check_word("o_ms_csr", XLEN'(o_ms_csr), XLEN'(k + 'h300));
      check_bit("o_ms_csr_wen", o_ms_csr_wen, k != 0);
      check_bit("o_ms_csr_inst_sel", o_ms_csr_inst_sel, 1'(k));
    end
    report_test("csr", e0);
  endtask

  task automatic store_one(input logic [MEM_OP_W-1:0] op, input int size, input int off);
    logic [XLEN-1:0]    base;
    logic [WMASK_W-1:0] exp_mask;
    logic [XLEN-1:0]    exp_data;
    int                 nr;
    int                 nw;
    @(posedge i_clk);
    #1;
    clear_fields();
    base       = rand64() & ~64'h7;
    i_rs1_data = base;
    i_imm      = XLEN'(off);
    i_src2_sel = SRC2_IMM;
    i_rs2_data = rand64();
    i_mem_wen  = 1'b1;
    i_mem_op   = op;
    exp_mask = '0;
    exp_data = '0;
    for (int k = 0; k < size; k++) begin
      exp_mask[off + k]             = 1'b1;
      exp_data[(off + k) * 8 +: 8] = i_rs2_data[k * 8 +: 8];
    end
    issue();
    wait_valid();
    @(negedge i_clk);
    check_word("o_sram_addr", XLEN'(o_sram_addr), XLEN'(base[31:0] + 32'(off)));
    check_mask("o_sram_wmask", o_sram_wmask, exp_mask);
    check_word("o_sram_wdata", o_sram_wdata, exp_data);
    check_bit("o_ms_mem_ren", o_ms_mem_ren, 1'b0);
    count_strobes(4, nr, nw);
    check_strobes("store", nr, nw, 0, 1);
  endtask

  task automatic load_one(input logic [MEM_OP_W-1:0] op);
    int nr;
    int nw;
    @(posedge i_clk);
    #1;
    clear_fields();
    i_rs1_data = rand64() & ~64'h7;
    i_src2_sel = SRC2_IMM;
    i_mem_ren  = 1'b1;
    i_gpr_wen  = 1'b1;
    i_mem_op   = op;
    issue();
    wait_valid();
    @(negedge i_clk);
    check_bit("o_ms_mem_ren", o_ms_mem_ren, 1'b1);
    check_word("o_ms_mem_op", XLEN'(o_ms_mem_op), XLEN'(op));
    count_strobes(4, nr, nw);
    check_strobes("load", nr, nw, 1, 0);
  endtask

  task automatic test_store();
    int e0;
    e0 = err_cnt;
    for (int off = 0; off < 8; off++) store_one(MEM_B, 1, off);
    for (int off = 0; off < 8; off += 2) store_one(MEM_H, 2, off);
    for (int off = 0; off < 8; off += 4) store_one(MEM_W, 4, off);
    store_one(MEM_D, 8, 0);
    load_one(MEM_D);
    load_one(MEM_WU);
    report_test("store", e0);
  endtask

  task automatic test_backpressure();
    int              e0;
    logic [XLEN-1:0] addr_a;
    logic [XLEN-1:0] addr_b;
    logic [XLEN-1:0] data_a;
    e0 = err_cnt;
    @(posedge i_clk);
    #1;
    i_ms_allowin = 1'b0;
    clear_fields();
    addr_a     = rand64() & ~64'h7;
    data_a     = rand64();
    i_rs1_data = addr_a;
    i_rs2_data = data_a;
    i_src2_sel = SRC2_IMM;
    i_mem_wen  = 1'b1;
    i_mem_op   = MEM_D;
    issue();
    wait_valid();
    // second store waits at the input while the first one stalls
    addr_b     = rand64() & ~64'h7;
    i_rs1_data = addr_b;
    i_ds_valid = 1'b1;
    repeat (4) begin
      @(negedge i_clk);
      check_bit("o_es_allowin", o_es_allowin, 1'b0);
      check_bit("o_ms_valid", o_ms_valid, 1'b1);
      check_bit("o_sram_wen", o_sram_wen, 1'b0);
      check_bit("o_sram_ren", o_sram_ren, 1'b0);
      check_word("o_ms_alu_result", o_ms_alu_result, addr_a);
      check_word("o_sram_wdata", o_sram_wdata, data_a);
      @(posedge i_clk);
      #1;
    end
    i_ms_allowin = 1'b1;
    @(negedge i_clk);
    check_bit("o_es_allowin", o_es_allowin, 1'b1);
    check_bit("o_sram_wen", o_sram_wen, 1'b1);
    check_word("o_sram_addr", XLEN'(o_sram_addr), XLEN'(addr_a[31:0]));
    @(posedge i_clk);  // first leaves and second enters
    #1;
    i_ds_valid = 1'b0;
    @(negedge i_clk);
    check_bit("o_ms_valid", o_ms_valid, 1'b1);
    check_bit("o_sram_wen", o_sram_wen, 1'b1);
    check_word("o_sram_addr", XLEN'(o_sram_addr), XLEN'(addr_b[31:0]));
    @(negedge i_clk);
    check_bit("o_ms_valid", o_ms_valid, 1'b0);
    check_bit("o_sram_wen", o_sram_wen, 1'b0);
    report_test("backpressure", e0);
  endtask

  task automatic bypass_case(input logic gw, input logic cw);
    logic [XLEN-1:0] rd_val;
    logic [XLEN-1:0] csr_val;
    @(posedge i_clk);
    #1;
    clear_fields();
    i_rs1_data  = rand64();
    i_rs2_data  = rand64();
    i_csr_rdata = rand64();
    i_csr_op    = CSR_RS;
    i_rd        = GPR_ADDR_W'($random(seed));
    i_csr       = CSR_ADDR_W'($random(seed));
    i_gpr_wen   = gw;
    i_csr_wen   = cw;
    rd_val  = model_alu(ALU_ADD, i_rs1_data, i_rs2_data, 1'b0);
    csr_val = model_csr(CSR_RS, i_csr_rdata, i_rs1_data, i_imm);
    issue();
    wait_valid();
    @(negedge i_clk);
    check_word("o_ms_rd", XLEN'(o_ms_rd), XLEN'(i_rd));
    check_word("o_ms_csr", XLEN'(o_ms_csr), XLEN'(i_csr));
    check_bit("o_ms_gpr_wen", o_ms_gpr_wen, gw);
    check_bit("o_ms_csr_wen", o_ms_csr_wen, cw);
    check_word("o_byp_rd", XLEN'(o_byp_rd), gw ? XLEN'(i_rd) : '0);
    check_word("o_byp_rd_data", o_byp_rd_data, gw ? rd_val : '0);
    check_word("o_byp_csr", XLEN'(o_byp_csr), cw ? XLEN'(i_csr) : '0);
    check_word("o_byp_csr_data", o_byp_csr_data, cw ? csr_val : '0);
    @(negedge i_clk);
    check_idle();  // stage drained
  endtask

  task automatic test_bypass();
    int e0;
    e0 = err_cnt;
    bypass_case(1'b1, 1'b0);
    bypass_case(1'b0, 1'b1);
    bypass_case(1'b1, 1'b1);
    bypass_case(1'b0, 1'b0);
    report_test("bypass", e0);
  endtask

  initial begin
    clear_fields();
    i_ms_allowin = 1'b1;
    i_arst_n     = 1'b0;
    test_reset();
    test_alu();
    test_csr();
    test_store();
    test_backpressure();
    test_bypass();
    repeat (2) @(posedge i_clk);
    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
verilog/ex_pkg.sv
verilog/ex_stage_ctrl.sv
verilog/ex_alu.sv
verilog/ex_csr_alu.sv
verilog/ex_store_align.sv
verilog/ex_top.sv
sim/tb_ex_top.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_STR  ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# fails unless the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_STR)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
